// File: src/ironhorse_pkg.sv
// Shared constants and packed bus, control and sample types used by every Iron Horse glue block
`default_nettype none

package ironhorse_pkg;

	// ====================
	// Widths and dividers
	// ====================

	// The main CPU sees an 11-bit I/O window
	localparam int IO_ADR_W = 11;
	// Free-running divider behind the integer sound enable
	localparam int DIV_W = 7;
	// 49.152 MHz divided by 16 gives the 3.072 MHz sound clock
	localparam int CEN_3M_DIV = 16;
	// The fractional enable pulses FRAC_N times in every FRAC_M clocks
	localparam int FRAC_W = 10;
	localparam logic [FRAC_W-1:0] FRAC_N = 10'd50;
	localparam logic [FRAC_W-1:0] FRAC_M = 10'd786;

	// ====================
	// I/O pages and mixing
	// ====================

	// Page codes come from address bits 10 to 8 of the I/O window
	localparam logic [2:0] PG_SOUND     = 3'd0;
	localparam logic [2:0] PG_DIP3_SIRQ = 3'd1;
	localparam logic [2:0] PG_DIP2_PAL  = 3'd2;
	localparam logic [2:0] PG_CTRL_DIP1 = 3'd3;

	// Each SSG channel is weighted against the FM channel in the final mix
	localparam logic [4:0] SSG_GAIN = 5'd24;
	// Unmapped reads float high on the board
	localparam logic [7:0] OPEN_BUS = 8'hFF;

	// Wishbone classic request from a CPU acting as master
	typedef struct packed {
		logic                cyc;
		logic                stb;
		logic                we;
		logic [IO_ADR_W-1:0] adr;
		logic [7:0]          dat;
	} wb_req_t;

	// Wishbone classic response from a slave
	typedef struct packed {
		logic       ack;
		logic [7:0] dat;
	} wb_rsp_t;

	// Joystick bits are down, up, right and left from 3 to 0
	typedef struct packed {
		logic [3:0] joy;
		logic [2:0] btn;
	} player_t;

	// Start bit 1 belongs to player 2
	typedef struct packed {
		logic [1:0] coin;
		logic [1:0] start;
		logic       service;
	} cabinet_t;

	typedef struct packed {
		logic [3:0] bank3;
		logic [7:0] bank2;
		logic [7:0] bank1;
	} dipsw_t;

	// Raw unsigned SSG channel levels
	typedef struct packed {
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] c;
	} ssg_set_t;

endpackage

`default_nettype wire

// File: src/clock_enables.sv
// Makes the sound clock enable from 49.152 MHz with an integer or fractional divider
`default_nettype none
`timescale 1ns/1ps

module clock_enables (
	input  wire  clk_49m,
	input  wire  sirq_clr,
	input  logic underclock_i,
	output logic cen_sound_o
);
	import ironhorse_pkg::*;

	logic [DIV_W-1:0]  div;
	logic              cen_int;
	logic [FRAC_W-1:0] frac_acc;
	logic [FRAC_W:0]   frac_sum;
	logic              frac_wrap;
	logic              cen_frac;

	// ====================
	// Integer enable
	// ====================

	// The low bits of the free-running divider roll over once every CEN_3M_DIV clocks
	always_ff @(posedge clk_49m or posedge sirq_clr) begin
		if (sirq_clr) begin
			div <= '0;
		end else begin
			div <= div + 1'b1;
		end
	end

	assign cen_int = (div[$clog2(CEN_3M_DIV)-1:0] == '0);

	// ====================
	// Fractional enable
	// ====================

	// The accumulator never exceeds FRAC_M + FRAC_N so one spare bit holds the sum
	assign frac_sum  = {1'b0, frac_acc} + {1'b0, FRAC_N};
	assign frac_wrap = (frac_sum >= {1'b0, FRAC_M});

	// A wrap removes FRAC_M and marks the next clock as an enable
	always_ff @(posedge clk_49m or posedge sirq_clr) begin
		if (sirq_clr) begin
			frac_acc <= '0;
			cen_frac <= 1'b0;
		end else begin
			frac_acc <= frac_wrap ? frac_sum[FRAC_W-1:0] - FRAC_M : frac_sum[FRAC_W-1:0];
			cen_frac <= frac_wrap;
		end
	end

	// Underclocked timing slows the main clocks so the sound chip needs the fractional rate
	assign cen_sound_o = underclock_i ? cen_frac : cen_int;

endmodule

`default_nettype wire

// File: src/control_input_mux.sv
// Selects the byte the main CPU reads from the controls page by address bits 1 to 0
`default_nettype none
`timescale 1ns/1ps

module control_input_mux (
	input  logic [1:0]                 sel_i,
	input  ironhorse_pkg::player_t     p1_i,
	input  ironhorse_pkg::player_t     p2_i,
	input  ironhorse_pkg::cabinet_t    cab_i,
	input  logic [7:0]                 dip1_i,
	output logic [7:0]                 ctrl_byte_o
);

	// Buttons are packed across players the way the PCB routes them
	// Each player byte carries the other player's button 2
	always_comb begin
		case (sel_i)
			2'd0: begin
				// DIP bank 1 shares the page with the controls
				ctrl_byte_o = dip1_i;
			end
			2'd1: begin
				ctrl_byte_o = {1'b1, p1_i.btn[2], p2_i.btn[1:0], p2_i.joy};
			end
			2'd2: begin
				ctrl_byte_o = {1'b1, p2_i.btn[2], p1_i.btn[1:0], p1_i.joy};
			end
			default: begin
				// Unused top bits of the cabinet byte read high
				ctrl_byte_o = {3'b111, cab_i.start, cab_i.service, cab_i.coin};
			end
		endcase
	end

endmodule

`default_nettype wire

// File: src/main_io_port.sv
// Wishbone slave for the main CPU I/O window with sound latch, palette latch and sound IRQ trigger
`default_nettype none
`timescale 1ns/1ps

module main_io_port (
	input  wire                     clk_49m,
	input  wire                     sirq_clr,
	input  ironhorse_pkg::wb_req_t  req_i,
	output ironhorse_pkg::wb_rsp_t  rsp_o,
	input  logic [7:0]              ctrl_byte_i,
	input  ironhorse_pkg::dipsw_t   dip_i,
	output logic [1:0]              ctrl_sel_o,
	output logic [7:0]              sound_latch_o,
	output logic [2:0]              palette_bank_o,
	output logic                    sirq_trigger_o
);
	import ironhorse_pkg::*;

	logic [2:0] page;
	logic       access;
	logic       ack_q;
	logic [7:0] rd_byte;
	logic [7:0] rd_dat_q;

	// The top three address bits pick one of eight pages
	assign page = req_i.adr[IO_ADR_W-1:IO_ADR_W-3];

	// A new access is taken only while ack is low
	assign access = req_i.cyc & req_i.stb & ~ack_q;

	// The controls mux needs the low address bits while the read is decoded
	assign ctrl_sel_o = req_i.adr[1:0];

	// ====================
	// Read decode
	// ====================

	always_comb begin
		case (page)
			PG_DIP3_SIRQ: begin
				// Bank 3 has only four switches and the upper nibble floats high
				rd_byte = {4'hF, dip_i.bank3};
			end
			PG_DIP2_PAL: begin
				rd_byte = dip_i.bank2;
			end
			PG_CTRL_DIP1: begin
				rd_byte = ctrl_byte_i;
			end
			default: begin
				rd_byte = OPEN_BUS;
			end
		endcase
	end

	// Read data is captured at the same edge that raises ack
	always_ff @(posedge clk_49m) begin
		if (access & ~req_i.we) begin
			rd_dat_q <= rd_byte;
		end
	end

	// ====================
	// Handshake and writes
	// ====================

	// Ack is high for exactly one cycle and the trigger pulses alongside it
	always_ff @(posedge clk_49m or posedge sirq_clr) begin
		if (sirq_clr) begin
			ack_q          <= 1'b0;
			sirq_trigger_o <= 1'b0;
		end else begin
			ack_q          <= access;
			sirq_trigger_o <= access & req_i.we & (page == PG_DIP3_SIRQ);
		end
	end

	// Latch writes land on the edge that raises ack
	always_ff @(posedge clk_49m or posedge sirq_clr) begin
		if (sirq_clr) begin
			sound_latch_o  <= '0;
			palette_bank_o <= '0;
		end else if (access & req_i.we) begin
			if (page == PG_SOUND) begin
				sound_latch_o <= req_i.dat;
			end
			// Only the low three bits reach the colour PROM address
			if (page == PG_DIP2_PAL) begin
				palette_bank_o <= req_i.dat[2:0];
			end
		end
	end

	assign rsp_o.ack = ack_q;
	assign rsp_o.dat = rd_dat_q;

endmodule

`default_nettype wire

// File: src/sound_cpu_port.sv
// Wishbone slave for the sound CPU that returns the sound latch and drives its interrupt line
`default_nettype none
`timescale 1ns/1ps

module sound_cpu_port (
	input  wire                     clk_49m,
	input  wire                     sirq_clr,
	input  ironhorse_pkg::wb_req_t  req_i,
	output ironhorse_pkg::wb_rsp_t  rsp_o,
	input  logic [7:0]              sound_latch_i,
	input  logic                    sirq_trigger_i,
	input  logic                    cen_sound_i,
	input  logic                    int_ack_i,
	output logic                    int_n_o
);

	logic       access;
	logic       ack_q;
	logic [7:0] rd_dat_q;
	logic       pending;
	logic       fire;

	// ====================
	// Latch read port
	// ====================

	assign access = req_i.cyc & req_i.stb & ~ack_q;

	// Every location reads the latch and writes are simply acknowledged
	always_ff @(posedge clk_49m or posedge sirq_clr) begin
		if (sirq_clr) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;
		end
	end

	always_ff @(posedge clk_49m) begin
		if (access) begin
			rd_dat_q <= sound_latch_i;
		end
	end

	assign rsp_o.ack = ack_q;
	assign rsp_o.dat = rd_dat_q;

	// ====================
	// Sound interrupt
	// ====================

	// The request is held until the sound clock domain picks it up
	// An acknowledge in the same cycle wins so the request is not lost
	assign fire = cen_sound_i & pending & ~int_ack_i;

	always_ff @(posedge clk_49m or posedge sirq_clr) begin
		if (sirq_clr) begin
			pending <= 1'b0;
			int_n_o <= 1'b1;
		end else begin
			pending <= sirq_trigger_i | (pending & ~fire);
			if (int_ack_i) begin
				int_n_o <= 1'b1;
			end else if (fire) begin
				int_n_o <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: src/audio_mixer.sv
// Registered mix of the FM channel and the three weighted SSG channels into one 16-bit sample
`default_nettype none
`timescale 1ns/1ps

module audio_mixer (
	input  wire                      clk_49m,
	input  wire                      sirq_clr,
	input  logic signed [15:0]       fm_i,
	input  ironhorse_pkg::ssg_set_t  ssg_i,
	output logic signed [15:0]       sound_o
);
	import ironhorse_pkg::*;

	logic        [9:0]  ssg_sum;
	logic        [14:0] ssg_mix;
	logic signed [17:0] fm_ext;
	logic signed [17:0] mix;

	// Three 8-bit levels sum to at most 765 which fits in ten bits
	assign ssg_sum = {2'b00, ssg_i.a} + {2'b00, ssg_i.b} + {2'b00, ssg_i.c};
	// The weighted sum stays below 2^15 and is always positive
	assign ssg_mix = ssg_sum * SSG_GAIN;

	// FM is sign extended before the SSG total is added
	assign fm_ext = fm_i;
	assign mix    = (fm_ext + $signed({3'b000, ssg_mix})) <<< 1;

	// The output keeps only the low 16 bits so loud passages wrap like the board
	always_ff @(posedge clk_49m or posedge sirq_clr) begin
		if (sirq_clr) begin
			sound_o <= '0;
		end else begin
			sound_o <= mix[15:0];
		end
	end

endmodule

`default_nettype wire

// File: src/ironhorse_io.sv
// Top level of the Iron Horse board glue that joins the CPU ports, enables, inputs and mixer
`default_nettype none
`timescale 1ns/1ps

module ironhorse_io (
	input  wire                      clk_49m,
	input  wire                      sirq_clr,
	input  ironhorse_pkg::wb_req_t   main_req_i,
	output ironhorse_pkg::wb_rsp_t   main_rsp_o,
	input  ironhorse_pkg::wb_req_t   snd_req_i,
	output ironhorse_pkg::wb_rsp_t   snd_rsp_o,
	input  ironhorse_pkg::player_t   p1_i,
	input  ironhorse_pkg::player_t   p2_i,
	input  ironhorse_pkg::cabinet_t  cab_i,
	input  ironhorse_pkg::dipsw_t    dip_i,
	input  logic                     underclock_i,
	input  logic                     snd_int_ack_i,
	output logic                     snd_int_n_o,
	output logic [2:0]               palette_bank_o,
	input  logic signed [15:0]       fm_i,
	input  ironhorse_pkg::ssg_set_t  ssg_i,
	output logic signed [15:0]       sound_o
);

	logic       cen_sound;
	logic [1:0] ctrl_sel;
	logic [7:0] ctrl_byte;
	logic [7:0] sound_latch;
	logic       sirq_trigger;

	// Sound clock enable follows the underclock setting
	clock_enables u_clock_enables (
		.clk_49m      (clk_49m),
		.sirq_clr     (sirq_clr),
		.underclock_i (underclock_i),
		.cen_sound_o  (cen_sound)
	);

	// Player controls and DIP bank 1 share one page of the I/O window
	control_input_mux u_control_input_mux (
		.sel_i       (ctrl_sel),
		.p1_i        (p1_i),
		.p2_i        (p2_i),
		.cab_i       (cab_i),
		.dip1_i      (dip_i.bank1),
		.ctrl_byte_o (ctrl_byte)
	);

	main_io_port u_main_io_port (
		.clk_49m        (clk_49m),
		.sirq_clr       (sirq_clr),
		.req_i          (main_req_i),
		.rsp_o          (main_rsp_o),
		.ctrl_byte_i    (ctrl_byte),
		.dip_i          (dip_i),
		.ctrl_sel_o     (ctrl_sel),
		.sound_latch_o  (sound_latch),
		.palette_bank_o (palette_bank_o),
		.sirq_trigger_o (sirq_trigger)
	);

	// The sound CPU sees the latch and its interrupt in the sound clock domain
	sound_cpu_port u_sound_cpu_port (
		.clk_49m        (clk_49m),
		.sirq_clr       (sirq_clr),
		.req_i          (snd_req_i),
		.rsp_o          (snd_rsp_o),
		.sound_latch_i  (sound_latch),
		.sirq_trigger_i (sirq_trigger),
		.cen_sound_i    (cen_sound),
		.int_ack_i      (snd_int_ack_i),
		.int_n_o        (snd_int_n_o)
	);

	audio_mixer u_audio_mixer (
		.clk_49m  (clk_49m),
		.sirq_clr (sirq_clr),
		.fm_i     (fm_i),
		.ssg_i    (ssg_i),
		.sound_o  (sound_o)
	);

endmodule

`default_nettype wire

// File: test/ironhorse_properties.sv
// Bound concurrent checks on the Wishbone slaves, the sound interrupt and the sound enable rate
`default_nettype none
`timescale 1ns/1ps

module ironhorse_properties (
	input wire  clk_49m,
	input wire  sirq_clr,
	input logic cyc_i,
	input logic stb_i,
	input logic ack_i,
	input logic cen_chk_i,
	input logic cen_i,
	input logic uc_i,
	input logic int_ack_i,
	input logic int_n_i
);
	import ironhorse_pkg::*;

	// Number of failed assertions in this instance
	int                fail_cnt = 0;
	logic              armed;
	logic [FRAC_W-1:0] win;
	logic [6:0]        cen_cnt;

	// Rate windows of FRAC_M clocks start on the second edge after reset
	// By then the registered fractional enable shows its first accumulator result
	always_ff @(posedge clk_49m or posedge sirq_clr) begin
		if (sirq_clr) begin
			armed   <= 1'b0;
			win     <= '0;
			cen_cnt <= '0;
		end else if (!armed) begin
			armed <= 1'b1;
		end else if (win == FRAC_M - 1'b1) begin
			win     <= '0;
			cen_cnt <= '0;
		end else begin
			win     <= win + 1'b1;
			cen_cnt <= cen_cnt + cen_i;
		end
	end

	ack_needs_req: assert property (@(posedge clk_49m) disable iff (sirq_clr)
		ack_i |-> (cyc_i & stb_i))
	else begin
		$error("ack is high without cyc and stb");
		fail_cnt++;
	end

	ack_single: assert property (@(posedge clk_49m) disable iff (sirq_clr)
		ack_i |=> !ack_i)
	else begin
		$error("ack stayed high for two cycles");
		fail_cnt++;
	end

	int_release: assert property (@(posedge clk_49m) disable iff (sirq_clr)
		int_ack_i |=> int_n_i)
	else begin
		$error("interrupt still low the cycle after its acknowledge");
		fail_cnt++;
	end

	// The first windows after reset hold 49 integer enables
	// The fractional enable repeats every 786 clocks with exactly 50 pulses
	cen_rate: assert property (@(posedge clk_49m) disable iff (sirq_clr)
		(cen_chk_i && armed && (win == FRAC_M - 1'b1))
		|-> ((cen_cnt + cen_i) == (uc_i ? 7'd50 : 7'd49)))
	else begin
		$error("sound enable count in a 786 clock window is wrong for the mode");
		fail_cnt++;
	end

endmodule

bind main_io_port ironhorse_properties u_props (
	.clk_49m   (clk_49m),
	.sirq_clr  (sirq_clr),
	.cyc_i     (req_i.cyc),
	.stb_i     (req_i.stb),
	.ack_i     (rsp_o.ack),
	.cen_chk_i (1'b0),
	.cen_i     (1'b0),
	.uc_i      (1'b0),
	.int_ack_i (1'b0),
	.int_n_i   (1'b1)
);

bind sound_cpu_port ironhorse_properties u_props (
	.clk_49m   (clk_49m),
	.sirq_clr  (sirq_clr),
	.cyc_i     (req_i.cyc),
	.stb_i     (req_i.stb),
	.ack_i     (rsp_o.ack),
	.cen_chk_i (1'b0),
	.cen_i     (1'b0),
	.uc_i      (1'b0),
	.int_ack_i (int_ack_i),
	.int_n_i   (int_n_o)
);

// The enable generator is the only block that sees both the mode and the enable
bind clock_enables ironhorse_properties u_props (
	.clk_49m   (clk_49m),
	.sirq_clr  (sirq_clr),
	.cyc_i     (1'b0),
	.stb_i     (1'b0),
	.ack_i     (1'b0),
	.cen_chk_i (1'b1),
	.cen_i     (cen_sound_o),
	.uc_i      (underclock_i),
	.int_ack_i (1'b0),
	.int_n_i   (1'b1)
);

`default_nettype wire

// File: test/tb_ironhorse.sv
// Self-checking testbench for the Iron Horse board glue, compiled from flist.f with top tb_ironhorse
`default_nettype none
`timescale 1ns/1ps

module tb_ironhorse;
	import ironhorse_pkg::*;

	// Each enable run covers two 786-cycle windows plus margin and the rest stays under 2000 cycles
	localparam int TIMEOUT_CYCLES = 20000;
	localparam int RATE_CYCLES    = 2 * 786 + 16;

	logic               clk_49m;
	logic               sirq_clr;
	wb_req_t            main_req;
	wb_rsp_t            main_rsp;
	wb_req_t            snd_req;
	wb_rsp_t            snd_rsp;
	player_t            p1;
	player_t            p2;
	cabinet_t           cab;
	dipsw_t             dip;
	logic               underclock;
	logic               snd_int_ack;
	logic               snd_int_n;
	logic [2:0]         palette_bank;
	logic signed [15:0] fm;
	ssg_set_t           ssg;
	logic signed [15:0] sound;

	integer      seed;
	int          cycles = 0;
	logic        mix_on;
	logic        exp_valid;
	logic [15:0] exp_mix;

	ironhorse_io UUT (
		.clk_49m        (clk_49m),
		.sirq_clr       (sirq_clr),
		.main_req_i     (main_req),
		.main_rsp_o     (main_rsp),
		.snd_req_i      (snd_req),
		.snd_rsp_o      (snd_rsp),
		.p1_i           (p1),
		.p2_i           (p2),
		.cab_i          (cab),
		.dip_i          (dip),
		.underclock_i   (underclock),
		.snd_int_ack_i  (snd_int_ack),
		.snd_int_n_o    (snd_int_n),
		.palette_bank_o (palette_bank),
		.fm_i           (fm),
		.ssg_i          (ssg),
		.sound_o        (sound)
	);

	// 8 ns period
	initial begin
		clk_49m = 1'b0;
		forever begin
			#4 clk_49m = ~clk_49m;
		end
	end

	always @(posedge clk_49m) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			abort_run("Timeout: the tests did not finish within the cycle limit");
		end
	end

	// ====================
	// Reference models
	// ====================

	// Read byte of the main I/O window from the page in bits 10 to 8
	function automatic logic [7:0] expected_read(input logic [10:0] adr);
		case (adr[10:8])
			3'd1: return {4'hF, dip.bank3};
			3'd2: return dip.bank2;
			3'd3: begin
				// Player bytes swap button 2 between the players
				case (adr[1:0])
					2'd0: return dip.bank1;
					2'd1: return {1'b1, p1.btn[2], p2.btn[1:0], p2.joy};
					2'd2: return {1'b1, p2.btn[2], p1.btn[1:0], p1.joy};
					default: return {3'b111, cab.start, cab.service, cab.coin};
				endcase
			end
			default: return 8'hFF;
		endcase
	endfunction

	// FM plus 24 times the SSG total, doubled and wrapped to 16 bits
	function automatic logic [15:0] expected_mix(input logic signed [15:0] f, input ssg_set_t s);
		int total;
		total = int'(f) + 24 * (int'(s.a) + int'(s.b) + int'(s.c));
		total = total * 2;
		return total[15:0];
	endfunction

	// ====================
	// Checking helpers
	// ====================

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp));
		end
	endtask

	// Failures counted by the checkers bound to the slaves and the enable generator
	function automatic int bound_failures();
		return UUT.u_main_io_port.u_props.fail_cnt + UUT.u_sound_cpu_port.u_props.fail_cnt
			+ UUT.u_clock_enables.u_props.fail_cnt;
	endfunction

	// A bound assertion failure ends the run at the next falling edge
	always @(negedge clk_49m) begin
		if (bound_failures() != 0) begin
			abort_run("A bound assertion on the bus slaves or the sound enable failed");
		end
	end

	// The comparing process samples the mixer inputs at the rising edge
	// The output of that same edge is compared at the following falling edge
	always @(posedge clk_49m) begin
		exp_valid <= mix_on & ~sirq_clr;
		exp_mix   <= expected_mix(fm, ssg);
	end

	always @(negedge clk_49m) begin
		if (exp_valid) begin
			check("sound_o", sound, exp_mix);
		end
	end

	// ====================
	// Stimulus helpers
	// ====================

	// Reset is held for three cycles and the enable mode only changes inside it
	task automatic apply_reset(input logic uc);
		@(negedge clk_49m);
		sirq_clr   = 1'b1;
		underclock = uc;
		repeat (3) @(negedge clk_49m);
		sirq_clr = 1'b0;
	endtask

	// One Wishbone classic access on the main bus or the sound bus
	// The request stays up through the ack cycle and drops after it
	task automatic bus_access(input logic snd, input logic we, input logic [10:0] adr,
		input logic [7:0] wdat, output logic [7:0] rdat);
		wb_req_t req;
		int      waited;
		req.cyc = 1'b1;
		req.stb = 1'b1;
		req.we  = we;
		req.adr = adr;
		req.dat = wdat;
		waited  = 0;
		@(negedge clk_49m);
		if (snd) begin
			snd_req = req;
		end else begin
			main_req = req;
		end
		do begin
			@(negedge clk_49m);
			waited++;
			if (waited > 8) begin
				abort_run("Bus access received no ack within 8 cycles");
			end
		end while (!(snd ? snd_rsp.ack : main_rsp.ack));
		check(snd ? "snd_rsp_o.ack latency" : "main_rsp_o.ack latency", 16'(waited), 16'd1);
		rdat = snd ? snd_rsp.dat : main_rsp.dat;
		@(negedge clk_49m);
		if (snd) begin
			snd_req = '0;
		end else begin
			main_req = '0;
		end
	endtask

	task automatic wait_int_fall();
		int waited;
		waited = 0;
		while (snd_int_n !== 1'b0) begin
			@(negedge clk_49m);
			waited++;
			if (waited > 40) begin
				abort_run("snd_int_n_o did not fall within 40 cycles of the trigger");
			end
		end
	endtask

	// ====================
	// Test sequence
	// ====================

	initial begin
		logic [10:0] adr;
		logic [7:0]  wdat;
		logic [7:0]  rd;
		int          start;
		seed        = 52068;
		sirq_clr    = 1'b0;
		main_req    = '0;
		snd_req     = '0;
		p1          = '0;
		p2          = '0;
		cab         = '0;
		dip         = '0;
		underclock  = 1'b0;
		snd_int_ack = 1'b0;
		fm          = '0;
		ssg         = '0;
		mix_on      = 1'b0;
		apply_reset(1'b0);

		// Every page and every select value with fresh switch and control settings
		repeat (4) begin
			@(negedge clk_49m);
			dip = 20'($random(seed));
			p1  = 7'($random(seed));
			p2  = 7'($random(seed));
			cab = 5'($random(seed));
			for (int pg = 0; pg < 8; pg++) begin
				for (int sel = 0; sel < 4; sel++) begin
					adr = {pg[2:0], 6'($random(seed)), sel[1:0]};
					bus_access(1'b0, 1'b0, adr, 8'h00, rd);
					check("main_rsp_o.dat", 16'(rd), 16'(expected_read(adr)));
				end
			end
		end

		// Sound latch round trip and palette bank latch
		repeat (8) begin
			wdat = 8'($random(seed));
			bus_access(1'b0, 1'b1, {3'd0, 8'($random(seed))}, wdat, rd);
			bus_access(1'b1, 1'b0, 11'($random(seed)), 8'h00, rd);
			check("snd_rsp_o.dat", 16'(rd), 16'(wdat));
			bus_access(1'b0, 1'b1, {3'd2, 8'($random(seed))}, wdat, rd);
			check("palette_bank_o", 16'(palette_bank), 16'(wdat[2:0]));
		end

		// Mixer with random FM and SSG sets
		mix_on = 1'b1;
		repeat (200) begin
			@(negedge clk_49m);
			fm  = 16'($random(seed));
			ssg = 24'($random(seed));
		end
		@(negedge clk_49m);
		mix_on = 1'b0;

		// Interrupt released by the acknowledge, then by reset
		bus_access(1'b0, 1'b1, {3'd1, 8'h00}, 8'h00, rd);
		wait_int_fall();
		@(negedge clk_49m);
		snd_int_ack = 1'b1;
		@(negedge clk_49m);
		check("snd_int_n_o", 16'(snd_int_n), 16'd1);
		snd_int_ack = 1'b0;
		bus_access(1'b0, 1'b1, {3'd1, 8'h00}, 8'h00, rd);
		wait_int_fall();
		@(negedge clk_49m);
		sirq_clr = 1'b1;
		#1;
		check("snd_int_n_o", 16'(snd_int_n), 16'd1);
		repeat (2) @(negedge clk_49m);
		sirq_clr = 1'b0;

		// Trigger and acknowledge for two rate windows in each enable mode
		for (int mode = 0; mode < 2; mode++) begin
			apply_reset(mode[0]);
			start = cycles;
			while (cycles - start < RATE_CYCLES) begin
				bus_access(1'b0, 1'b1, {3'd1, 8'h00}, 8'h00, rd);
				wait_int_fall();
				@(negedge clk_49m);
				snd_int_ack = 1'b1;
				@(negedge clk_49m);
				snd_int_ack = 1'b0;
				check("snd_int_n_o", 16'(snd_int_n), 16'd1);
			end
		end

		repeat (4) @(negedge clk_49m);
		if (bound_failures() == 0) begin
			$display("Result: PASSED");
			$finish;
		end else begin
			abort_run("Bound assertions on the bus slaves reported failures");
		end
	end

endmodule

`default_nettype wire

// File: flist.f
src/ironhorse_pkg.sv
src/clock_enables.sv
src/control_input_mux.sv
src/main_io_port.sv
src/sound_cpu_port.sv
src/audio_mixer.sv
src/ironhorse_io.sv
test/ironhorse_properties.sv
test/tb_ironhorse.sv

// File: Makefile
VERILATOR   ?= verilator
TOP         ?= tb_ironhorse
FLIST       ?= flist.f
OBJ_DIR     ?= obj_dir
VFLAGS      ?= --binary --timing --assert -Wno-fatal
ERROR_LIMIT ?= 100

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+$(ERROR_LIMIT)

clean:
	rm -rf $(OBJ_DIR)
